/* verilog/bpPkg.sv */
/*
 * Branch predictor shared types: widths, branch kinds, counter states
 * and the structs that carry fetch, prediction, resolve and update data
 */
`default_nettype none

package bpPkg;

    localparam int PC_W      = 32;
    localparam int HIST_BITS = 5;

    typedef logic [PC_W-1:0]      pcT;
    typedef logic [HIST_BITS-1:0] histT;

    // Branch kind seen at execute
    typedef enum logic [2:0] {
        kindNone,
        kindBeq,
        kindBne,
        kindJal,
        kindJalr
    } brKindE;

    // Two-bit saturating direction counter
    typedef enum logic [1:0] {
        strongNotTaken,
        weakNotTaken,
        weakTaken,
        strongTaken
    } ctrStateE;

    typedef struct packed {
        pcT   pc;
        logic isBranch;
    } fetchReqT;

    typedef struct packed {
        logic taken;
        pcT   target;
        histT phtIndex;
    } predictionT;

    typedef struct packed {
        pcT     pc;
        brKindE kind;
        logic   zero;
        pcT     target;
        logic   predictedTaken;
        histT   phtIndex;
    } resolveT;

    // Table writes from execute, already qualified by the resolve strobe
    typedef struct packed {
        logic btbWe;
        pcT   btbTarget;
        pcT   pc;
        logic phtWe;
        logic phtInc;
        histT phtIndex;
        logic historyReset;
    } updateT;

endpackage

`default_nettype wire

/* verilog/branchTargetBuffer.sv */
/*
 * Branch target buffer: direct-mapped, untagged target store with a
 * valid bit per entry, combinational read and write at resolve
 */
`default_nettype none
`timescale 1ns/1ps

module branchTargetBuffer
    import bpPkg::*;
#(
    parameter int btbEntries = 32
) (
    input  logic   clk,
    input  logic   reset,
    input  pcT     lookupPc_i,
    input  updateT update_i,
    output logic   hit_o,
    output pcT     target_o
);

    localparam int idxW = $clog2(btbEntries);

    typedef logic [idxW-1:0] btbIdxT;

    pcT                    targets [btbEntries];
    logic [btbEntries-1:0] valid;
    btbIdxT                readIdx;
    btbIdxT                writeIdx;

    // Word-aligned PCs, so the index starts above bit 1
    assign readIdx  = lookupPc_i[idxW+1:2];
    assign writeIdx = update_i.pc[idxW+1:2];

    assign hit_o    = valid[readIdx];
    assign target_o = targets[readIdx];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
        end else if (update_i.btbWe) begin
            valid[writeIdx] <= 1'b1;
        end
    end

    // Targets written by taken resolutions
    always_ff @(posedge clk) begin
        if (update_i.btbWe) begin
            targets[writeIdx] <= update_i.btbTarget;
        end
    end

endmodule

`default_nettype wire

/* verilog/patternHistoryTable.sv */
/*
 * Pattern history table: gshare-indexed array of two-bit saturating
 * direction counters, trained by resolved conditional branches
 */
`default_nettype none
`timescale 1ns/1ps

module patternHistoryTable
    import bpPkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  histT   lookupIndex_i,
    input  updateT update_i,
    output logic   taken_o
);

    localparam int phtEntries = 2 ** HIST_BITS;

    ctrStateE ctr [phtEntries];
    ctrStateE readState;
    ctrStateE writeOld;
    ctrStateE writeNew;

    assign readState = ctr[lookupIndex_i];
    assign taken_o   = (readState == weakTaken) || (readState == strongTaken);

    // Next counter state for the entry being trained
    always_comb begin
        writeOld = ctr[update_i.phtIndex];
        writeNew = writeOld;
        case (writeOld)
            strongNotTaken: writeNew = update_i.phtInc ? weakNotTaken : strongNotTaken;
            weakNotTaken:   writeNew = update_i.phtInc ? weakTaken : strongNotTaken;
            weakTaken:      writeNew = update_i.phtInc ? strongTaken : weakNotTaken;
            strongTaken:    writeNew = update_i.phtInc ? strongTaken : weakTaken;
            default:        writeNew = weakNotTaken;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < phtEntries; i++) begin
                ctr[i] <= weakNotTaken;
            end
        end else if (update_i.phtWe) begin
            ctr[update_i.phtIndex] <= writeNew;
        end
    end

    // A trained entry moves at most one state, and only in the trained direction
    stepA: assert property (
        @(posedge clk) disable iff (reset)
        update_i.phtWe |=>
            ($past(update_i.phtInc) ?
                ((int'(ctr[$past(update_i.phtIndex)]) - int'($past(writeOld)))
                    inside {0, 1}) :
                ((int'(ctr[$past(update_i.phtIndex)]) - int'($past(writeOld)))
                    inside {-1, 0}))
    ) else $error("PHT counter stepped by more than one state");

endmodule

`default_nettype wire

/* verilog/fetchLookup.sv */
/*
 * Fetch-side lookup: global history register, gshare index and the
 * registered direction and target prediction for each fetch strobe
 */
`default_nettype none
`timescale 1ns/1ps

module fetchLookup
    import bpPkg::*;
#(
    parameter int btbEntries = 32
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       fetchValid_i,
    input  fetchReqT   fetch_i,
    input  logic       historyReset_i,
    input  logic       btbHit_i,
    input  pcT         btbTarget_i,
    input  logic       ctrTaken_i,
    output pcT         lookupPc_o,
    output histT       lookupIndex_o,
    output logic       predValid_o,
    output predictionT prediction_o
);

    localparam int btbIdxW = $clog2(btbEntries);

    // BTB indexing drops low PC bits, so a non power of two size would alias
    if ((1 << btbIdxW) != btbEntries) begin : badBtbSize
        $error("btbEntries must be a power of two");
    end

    histT       history;
    logic       takenNow;
    pcT         targetNow;
    predictionT predNow;

    assign lookupPc_o    = fetch_i.pc;
    assign lookupIndex_o = history ^ fetch_i.pc[HIST_BITS+1:2];

    // Jumps follow the BTB alone, branches also need a taken counter
    assign takenNow  = btbHit_i && (!fetch_i.isBranch || ctrTaken_i);
    assign targetNow = takenNow ? btbTarget_i : fetch_i.pc + PC_W'(4);

    always_comb begin
        predNow.taken    = takenNow;
        predNow.target   = targetNow;
        predNow.phtIndex = lookupIndex_o;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            predValid_o <= 1'b0;
        end else begin
            predValid_o <= fetchValid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (fetchValid_i) begin
            prediction_o <= predNow;
        end
    end

    // Mispredict clear takes priority over a same-cycle branch shift
    always_ff @(posedge clk) begin
        if (reset) begin
            history <= '0;
        end else if (historyReset_i) begin
            history <= '0;
        end else if (fetchValid_i && fetch_i.isBranch) begin
            history <= {history[HIST_BITS-2:0], takenNow};
        end
    end

    // Clear from resolve always lands, even against a branch fetch
    clearWinsA: assert property (
        @(posedge clk) disable iff (reset)
        historyReset_i |=> (history == '0)
    ) else $error("History not cleared after mispredict");

endmodule

`default_nettype wire

/* verilog/branchResolve.sv */
/*
 * Execute-stage resolution: actual outcome, mispredict detection,
 * redirect PC and the table update strobes
 */
`default_nettype none
`timescale 1ns/1ps

module branchResolve
    import bpPkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    resolveValid_i,
    input  resolveT resolve_i,
    output updateT  update_o,
    output logic    mispredict_o,
    output pcT      redirectPc_o
);

    logic isCond;
    logic isJump;
    logic actualTaken;
    logic wrongNow;
    pcT   redirectNow;

    assign isCond = (resolve_i.kind == kindBeq) || (resolve_i.kind == kindBne);
    assign isJump = (resolve_i.kind == kindJal) || (resolve_i.kind == kindJalr);

    // beq taken on zero, bne taken on nonzero, jumps always taken
    assign actualTaken = ((resolve_i.kind == kindBeq) && resolve_i.zero) ||
                         ((resolve_i.kind == kindBne) && !resolve_i.zero) ||
                         isJump;

    assign wrongNow    = actualTaken != resolve_i.predictedTaken;
    assign redirectNow = actualTaken ? resolve_i.target : resolve_i.pc + PC_W'(4);

    always_comb begin
        update_o.btbWe        = resolveValid_i && actualTaken;
        update_o.btbTarget    = resolve_i.target;
        update_o.pc           = resolve_i.pc;
        update_o.phtWe        = resolveValid_i && isCond;
        update_o.phtInc       = actualTaken;
        update_o.phtIndex     = resolve_i.phtIndex;
        update_o.historyReset = resolveValid_i && wrongNow;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mispredict_o <= 1'b0;
        end else begin
            mispredict_o <= resolveValid_i && wrongNow;
        end
    end

    always_ff @(posedge clk) begin
        if (resolveValid_i) begin
            redirectPc_o <= redirectNow;
        end
    end

    // A non-branch only redirects when fetch wrongly predicted it taken
    noneA: assert property (
        @(posedge clk) disable iff (reset)
        (resolveValid_i && (resolve_i.kind == kindNone) && !resolve_i.predictedTaken)
            |=> !mispredict_o
    ) else $error("Mispredict raised for a non-branch predicted not taken");

endmodule

`default_nettype wire

/* verilog/branchPredictor.sv */
/*
 * Branch prediction unit top: BTB, gshare PHT and history at fetch,
 * resolution and training at execute
 */
`default_nettype none
`timescale 1ns/1ps

module branchPredictor
    import bpPkg::*;
#(
    parameter int btbEntries = 32
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       fetchValid_i,
    input  fetchReqT   fetch_i,
    input  logic       resolveValid_i,
    input  resolveT    resolve_i,
    output logic       predValid_o,
    output predictionT prediction_o,
    output logic       mispredict_o,
    output pcT         redirectPc_o
);

    pcT     lookupPc;
    histT   lookupIndex;
    logic   btbHit;
    pcT     btbTarget;
    logic   ctrTaken;
    updateT update;

    fetchLookup #(
        .btbEntries(btbEntries)
    ) fetchLookup_i (
        .clk           (clk),
        .reset         (reset),
        .fetchValid_i  (fetchValid_i),
        .fetch_i       (fetch_i),
        .historyReset_i(update.historyReset),
        .btbHit_i      (btbHit),
        .btbTarget_i   (btbTarget),
        .ctrTaken_i    (ctrTaken),
        .lookupPc_o    (lookupPc),
        .lookupIndex_o (lookupIndex),
        .predValid_o   (predValid_o),
        .prediction_o  (prediction_o)
    );

    branchTargetBuffer #(
        .btbEntries(btbEntries)
    ) branchTargetBuffer_i (
        .clk       (clk),
        .reset     (reset),
        .lookupPc_i(lookupPc),
        .update_i  (update),
        .hit_o     (btbHit),
        .target_o  (btbTarget)
    );

    patternHistoryTable patternHistoryTable_i (
        .clk          (clk),
        .reset        (reset),
        .lookupIndex_i(lookupIndex),
        .update_i     (update),
        .taken_o      (ctrTaken)
    );

    branchResolve branchResolve_i (
        .clk           (clk),
        .reset         (reset),
        .resolveValid_i(resolveValid_i),
        .resolve_i     (resolve_i),
        .update_o      (update),
        .mispredict_o  (mispredict_o),
        .redirectPc_o  (redirectPc_o)
    );

endmodule

`default_nettype wire

/* test/predictionChecker.sv */
/*
 * Prediction checker: compares the DUT's prediction and redirect outputs
 * with the reference model, one cycle after each strobe
 */
`default_nettype none
`timescale 1ns/1ps

module predictionChecker
    import bpPkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       expValid_i,
    input  predictionT expPred_i,
    input  logic       expMis_i,
    input  pcT         expRedirect_i,
    input  logic       predValid_i,
    input  predictionT prediction_i,
    input  logic       mispredict_i,
    input  pcT         redirectPc_i,
    output int         timingErrors_o,
    output int         valueErrors_o
);

    logic       validQ;
    predictionT predQ;
    logic       misQ;
    pcT         redirectQ;
    int         timingErrors = 0;
    int         valueErrors = 0;

    assign timingErrors_o = timingErrors;
    assign valueErrors_o  = valueErrors;

    // Expected values ride one cycle behind the strobe, as the DUT outputs do
    always @(posedge clk) begin
        validQ    <= expValid_i;
        predQ     <= expPred_i;
        misQ      <= expMis_i;
        redirectQ <= expRedirect_i;
    end

    // Outputs settle after the rising edge
    always @(negedge clk) begin
        if (!reset) begin
            if (predValid_i !== validQ) begin
                $display("[ERROR] %0t predValid_o: got %b, expected %b",
                         $time, predValid_i, validQ);
                timingErrors++;
            end else if (validQ && (prediction_i !== predQ)) begin
                $display("[ERROR] %0t prediction_o: got %b/%h/%h, expected %b/%h/%h",
                         $time, prediction_i.taken, prediction_i.target,
                         prediction_i.phtIndex, predQ.taken, predQ.target, predQ.phtIndex);
                valueErrors++;
            end
            if (mispredict_i !== misQ) begin
                $display("[ERROR] %0t mispredict_o: got %b, expected %b",
                         $time, mispredict_i, misQ);
                timingErrors++;
            end else if (misQ && (redirectPc_i !== redirectQ)) begin
                $display("[ERROR] %0t redirectPc_o: got %h, expected %h",
                         $time, redirectPc_i, redirectQ);
                valueErrors++;
            end
        end
    end

endmodule

`default_nettype wire

/* test/branchPredictorTb.sv */
/*
 * Branch predictor testbench: directed learning, training and history
 * cases, then a random run against the reference model
 */
`default_nettype none
`timescale 1ns/1ps

module branchPredictorTb
    import bpPkg::*;
();

    localparam int btbEntries = 32;
    localparam int waitLimit  = 20;
    localparam int randomOps  = 2000;

    logic       clk = 1'b0;
    logic       reset;
    logic       fetchValid;
    fetchReqT   fetchReq;
    logic       resolveValid;
    resolveT    resolveReq;
    logic       predValid;
    predictionT prediction;
    logic       mispredict;
    pcT         redirectPc;

    logic       expValid;
    predictionT expPred;
    logic       expMis;
    pcT         expRedirect;

    // Reference copies of the predictor state
    histT mdlHist;
    logic mdlValid [btbEntries];
    pcT   mdlTarget [btbEntries];
    int   mdlCtr [2**HIST_BITS];

    int          timingErrors;
    int          valueErrors;
    int          directedErrors = 0;
    int          timeouts = 0;
    logic [31:0] rngState = 32'h51a5;

    always #10 clk = ~clk;

    branchPredictor #(
        .btbEntries(btbEntries)
    ) branchPredictor_i (
        .clk           (clk),
        .reset         (reset),
        .fetchValid_i  (fetchValid),
        .fetch_i       (fetchReq),
        .resolveValid_i(resolveValid),
        .resolve_i     (resolveReq),
        .predValid_o   (predValid),
        .prediction_o  (prediction),
        .mispredict_o  (mispredict),
        .redirectPc_o  (redirectPc)
    );

    predictionChecker predictionChecker_i (
        .clk           (clk),
        .reset         (reset),
        .expValid_i    (expValid),
        .expPred_i     (expPred),
        .expMis_i      (expMis),
        .expRedirect_i (expRedirect),
        .predValid_i   (predValid),
        .prediction_i  (prediction),
        .mispredict_i  (mispredict),
        .redirectPc_i  (redirectPc),
        .timingErrors_o(timingErrors),
        .valueErrors_o (valueErrors)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic fetchReqT makeFetch(input pcT pc, input logic isBranch);
        fetchReqT f;
        f.pc       = pc;
        f.isBranch = isBranch;
        return f;
    endfunction

    function automatic resolveT makeResolve(input brKindE kind, input pcT pc, input logic zero,
                                            input pcT target, input logic predTaken,
                                            input histT idx);
        resolveT r;
        r.pc             = pc;
        r.kind           = kind;
        r.zero           = zero;
        r.target         = target;
        r.predictedTaken = predTaken;
        r.phtIndex       = idx;
        return r;
    endfunction

    // Expected prediction and redirect for one edge, then the table and history updates
    function automatic void predictModel(input logic fv, input fetchReqT f, input logic rv,
                                         input resolveT r, output predictionT pred,
                                         output logic mis, output pcT redir);
        histT idx;
        int   rdIdx;
        int   wrIdx;
        logic actual;
        idx           = mdlHist ^ f.pc[HIST_BITS+1:2];
        rdIdx         = (f.pc >> 2) % btbEntries;
        wrIdx         = (r.pc >> 2) % btbEntries;
        pred.phtIndex = idx;
        pred.taken    = mdlValid[rdIdx] && (!f.isBranch || mdlCtr[idx] >= 2);
        pred.target   = pred.taken ? mdlTarget[rdIdx] : f.pc + 32'd4;
        actual = (r.kind == kindBeq && r.zero) || (r.kind == kindBne && !r.zero) ||
                 r.kind == kindJal || r.kind == kindJalr;
        mis    = rv && (actual != r.predictedTaken);
        redir  = actual ? r.target : r.pc + 32'd4;
        if (rv && actual) begin
            mdlValid[wrIdx]  = 1'b1;
            mdlTarget[wrIdx] = r.target;
        end
        if (rv && (r.kind == kindBeq || r.kind == kindBne)) begin
            if (actual && mdlCtr[r.phtIndex] < 3) begin
                mdlCtr[r.phtIndex]++;
            end else if (!actual && mdlCtr[r.phtIndex] > 0) begin
                mdlCtr[r.phtIndex]--;
            end
        end
        if (mis) begin
            mdlHist = '0;
        end else if (fv && f.isBranch) begin
            mdlHist = {mdlHist[HIST_BITS-2:0], pred.taken};
        end
    endfunction

    function automatic void checkValue(input string name, input logic [31:0] got,
                                       input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
            directedErrors++;
        end
    endfunction

    task automatic driveCycle(input logic fv, input fetchReqT f, input logic rv,
                              input resolveT r);
        predictionT pred;
        logic       mis;
        pcT         redir;
        @(posedge clk);
        fetchValid   <= fv;
        fetchReq     <= f;
        resolveValid <= rv;
        resolveReq   <= r;
        predictModel(fv, f, rv, r, pred, mis, redir);
        expValid    <= fv;
        expPred     <= pred;
        expMis      <= mis;
        expRedirect <= redir;
    endtask

    task automatic idleCycles(input int n);
        repeat (n) driveCycle(1'b0, '0, 1'b0, '0);
    endtask

    task automatic fetchAndCheck(input pcT pc, input logic isBranch, input logic taken,
                                 input pcT target, input histT idx);
        int n;
        n = 0;
        driveCycle(1'b1, makeFetch(pc, isBranch), 1'b0, '0);
        idleCycles(1);
        @(negedge clk);
        while (!predValid && n < waitLimit) begin
            @(negedge clk);
            n++;
        end
        if (!predValid) begin
            $display("Timeout: no prediction came back for PC %h", pc);
            timeouts++;
        end else begin
            checkValue("prediction_o.taken", 32'(prediction.taken), 32'(taken));
            checkValue("prediction_o.target", prediction.target, target);
            checkValue("prediction_o.phtIndex", 32'(prediction.phtIndex), 32'(idx));
        end
    endtask

    task automatic resolveAndCheck(input resolveT r, input pcT redirect);
        int n;
        n = 0;
        driveCycle(1'b0, '0, 1'b1, r);
        idleCycles(1);
        @(negedge clk);
        while (!mispredict && n < waitLimit) begin
            @(negedge clk);
            n++;
        end
        if (!mispredict) begin
            $display("Timeout: no mispredict came back for PC %h", r.pc);
            timeouts++;
        end else begin
            checkValue("redirectPc_o", redirectPc, redirect);
        end
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        reset        = 1'b1;
        fetchValid   = 1'b0;
        fetchReq     = '0;
        resolveValid = 1'b0;
        resolveReq   = '0;
        expValid     = 1'b0;
        expPred      = '0;
        expMis       = 1'b0;
        expRedirect  = '0;
        mdlHist      = '0;
        for (int i = 0; i < btbEntries; i++) begin
            mdlValid[i]  = 1'b0;
            mdlTarget[i] = '0;
        end
        for (int i = 0; i < 2**HIST_BITS; i++) begin
            mdlCtr[i] = 1;
        end
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        // Cold tables predict fall-through
        fetchAndCheck(32'h114, 1'b1, 1'b0, 32'h118, 5'd5);

        // Jump learning
        resolveAndCheck(makeResolve(kindJal, 32'h300, 1'b0, 32'h500, 1'b0, 5'd0), 32'h500);
        fetchAndCheck(32'h300, 1'b0, 1'b1, 32'h500, 5'd0);

        // Counter training at index 2, with not-taken redirects to PC plus 4
        resolveAndCheck(makeResolve(kindBeq, 32'h408, 1'b1, 32'h600, 1'b0, 5'd2), 32'h600);
        driveCycle(1'b0, '0, 1'b1, makeResolve(kindBeq, 32'h408, 1'b1, 32'h600, 1'b1, 5'd2));
        fetchAndCheck(32'h408, 1'b1, 1'b1, 32'h600, 5'd2);
        resolveAndCheck(makeResolve(kindBeq, 32'h408, 1'b0, 32'h600, 1'b1, 5'd2), 32'h40c);
        fetchAndCheck(32'h408, 1'b1, 1'b1, 32'h600, 5'd2);
        resolveAndCheck(makeResolve(kindBeq, 32'h408, 1'b0, 32'h600, 1'b1, 5'd2), 32'h40c);
        fetchAndCheck(32'h408, 1'b1, 1'b0, 32'h40c, 5'd2);

        // History shifts into the index, and a mispredict clear beats a branch shift
        driveCycle(1'b0, '0, 1'b1, makeResolve(kindBeq, 32'h408, 1'b1, 32'h600, 1'b1, 5'd2));
        fetchAndCheck(32'h408, 1'b1, 1'b1, 32'h600, 5'd2);
        fetchAndCheck(32'h408, 1'b1, 1'b0, 32'h40c, 5'd3);
        fetchAndCheck(32'h408, 1'b1, 1'b0, 32'h40c, 5'd0);
        driveCycle(1'b1, makeFetch(32'h408, 1'b1), 1'b1,
                   makeResolve(kindJal, 32'h300, 1'b0, 32'h500, 1'b0, 5'd0));
        fetchAndCheck(32'h408, 1'b1, 1'b1, 32'h600, 5'd2);

        // Random back-to-back traffic over a small PC pool so the BTB aliases
        for (int i = 0; i < randomOps; i++) begin
            rngState = xorshift(rngState);
            a        = rngState;
            rngState = xorshift(rngState);
            b        = rngState;
            driveCycle(a[0], makeFetch(32'h1000 + {a[8:2], 2'b00}, a[1]), b[0],
                       makeResolve(brKindE'(b[3:1] % 3'd5), 32'h1000 + {b[12:6], 2'b00},
                                   b[4], 32'h2000 + {a[31:22], 2'b00}, b[5], b[17:13]));
        end
        idleCycles(4);

        $display("Error counts: timing %0d, value %0d, directed %0d, timeouts %0d",
                 timingErrors, valueErrors, directedErrors, timeouts);
        if (timingErrors + valueErrors + directedErrors + timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* branchPredictor.f */
verilog/bpPkg.sv
verilog/branchTargetBuffer.sv
verilog/patternHistoryTable.sv
verilog/fetchLookup.sv
verilog/branchResolve.sv
verilog/branchPredictor.sv
test/predictionChecker.sv
test/branchPredictorTb.sv
